/* verif/ps_ctrl_vectors.txt */
# op addr data pslverr rdata, all hex. W write, R read and compare, P poll STATUS until idle.
# data is ignored for R and P, rdata is ignored for W and P.
R 04 00000000 0 00000004
R 08 00000000 0 00000000
R 0C 00000000 0 00000000
R 10 00000000 0 00000000
W 00 00010005 0 00000000
W 00 00010003 1 00000000
P 08 00000000 0 00000000
R 0C 00000000 0 00000005
R 10 00000000 0 00000005
W 04 00000000 0 00000000
W 00 00000007 0 00000000
P 08 00000000 0 00000000
R 0C 00000000 0 FFFFFFFE
R 10 00000000 0 0000000C
R 20 00000000 1 00000000
W 08 00000001 1 00000000
W 00 00010000 0 00000000
R 08 00000000 0 00000000
W 14 00000001 0 00000000
R 0C 00000000 0 00000000
R 10 00000000 0 00000000
W 04 00000007 0 00000000
W 00 00010003 0 00000000
P 08 00000000 0 00000000
R 0C 00000000 0 00000003
R 10 00000000 0 00000003
R 04 00000000 0 00000007

/* ps_ctrl_top.f */
+incdir+design
design/ps_pkg.sv
design/ps_apb_decode.sv
design/ps_step_engine.sv
design/ps_position_track.sv
design/ps_ctrl_top.sv
verif/ps_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ps_ctrl_tb
FILELIST  := ps_ctrl_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) design/ps_defines.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation prints the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

/* verif/ps_ctrl_tb.sv */
`timescale 1ns/1ps
`include "ps_defines.svh"
`default_nettype none

module ps_ctrl_tb;

    logic                  clk;
    logic                  aresetn;
    logic [`PS_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`PS_DATA_W-1:0] pwdata;
    logic [`PS_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  psen;
    logic                  psincdec;
    logic                  psdone;

    // one entry per vector line.
    logic [7:0]            op_q[$];
    logic [`PS_ADDR_W-1:0] addr_q[$];
    logic [`PS_DATA_W-1:0] data_q[$];
    logic                  err_q[$];
    logic [`PS_DATA_W-1:0] rdata_q[$];

    int unsigned           cycle = 0;
    int unsigned           limit = 100000;
    int unsigned           access_cycle = 0;
    int unsigned           psen_seen = 0;
    int unsigned           psen_expected = 0;
    int unsigned           ref_cycle = 0;
    int unsigned           ref_offset = 0;
    logic [`PS_STEP_W-1:0] shadow_gap = `PS_GAP_RESET;
    logic [`PS_STEP_W-1:0] shadow_pos = '0;
    logic [`PS_STEP_W-1:0] shadow_count = '0;
    logic                  shadow_dir = 1'b0;

    ps_ctrl_top ps_ctrl_top_inst (
        .clk      (clk),
        .aresetn  (aresetn),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .psen     (psen),
        .psincdec (psincdec),
        .psdone   (psdone)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $fatal(1, "stopped by timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // setup, access, then back to idle.
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        check("pready", 32'(pready), 32'd1);
        rdata        = prdata;
        err          = pslverr;
        access_cycle = cycle;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic track_write(input logic [7:0] addr, input logic [31:0] data);
        if (addr == `PS_REG_GAP) begin
            shadow_gap = data[`PS_STEP_W-1:0];
        end else if (addr == `PS_REG_CLEAR && data[0]) begin
            shadow_pos   = '0;
            shadow_count = '0;
        end else if (addr == `PS_REG_CMD && data[`PS_STEP_W-1:0] != '0) begin
            shadow_dir    = data[`PS_STEP_W];
            shadow_pos    = data[`PS_STEP_W] ? shadow_pos + data[`PS_STEP_W-1:0]
                                             : shadow_pos - data[`PS_STEP_W-1:0];
            shadow_count  = shadow_count + data[`PS_STEP_W-1:0];
            psen_expected = psen_expected + data[`PS_STEP_W-1:0];
            ref_cycle     = access_cycle;
            ref_offset    = shadow_gap + 1; // first psen after the command.
        end
    endtask

    // clock manager model answers each psen after 1 to 8 cycles.
    initial begin : psdone_model
        int unsigned delay;
        void'($urandom(32'hb738_fb5e));
        psdone = 1'b0;
        forever begin
            @(posedge clk);
            if (aresetn && psen) begin
                delay = 1 + ($urandom % 8);
                repeat (delay) @(negedge clk);
                psdone = 1'b1;
                @(negedge clk);
                psdone = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (aresetn) begin
            if (psen) begin
                psen_seen = psen_seen + 1;
                check("psincdec", 32'(psincdec), 32'(shadow_dir));
                check("psen_delay", cycle - ref_cycle, ref_offset);
            end
            if (psdone) begin
                ref_cycle  = cycle;
                ref_offset = shadow_gap + 2; // gap plus the step_done slot.
            end
        end
    end

    initial begin : run
        int                    fd;
        int                    code;
        int unsigned           parse_gap;
        logic [8*16-1:0]       tok;
        logic [8*96-1:0]       line;
        logic [`PS_ADDR_W-1:0] a;
        logic [`PS_DATA_W-1:0] d;
        logic [`PS_DATA_W-1:0] r;
        logic                  e;
        logic [`PS_DATA_W-1:0] got_data;
        logic                  got_err;

        aresetn = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        fd = $fopen("verif/ps_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verif/ps_ctrl_vectors.txt");
            $display("TEST FAILED");
            $fatal(1, "no vectors");
        end
        parse_gap = `PS_GAP_RESET;
        limit     = 20;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1 && tok[7:0] == "#") begin
                code = $fgets(line, fd); // comment line.
            end else if (code == 1) begin
                code = $fscanf(fd, "%h %h %h %h", a, d, e, r);
                op_q.push_back(tok[7:0]);
                addr_q.push_back(a);
                data_q.push_back(d);
                err_q.push_back(e);
                rdata_q.push_back(r);
                limit = limit + 50;
                if (tok[7:0] == "W" && a == `PS_REG_GAP)
                    parse_gap = d[`PS_STEP_W-1:0];
                if (tok[7:0] == "W" && a == `PS_REG_CMD && !e)
                    limit = limit + d[`PS_STEP_W-1:0] * (parse_gap + 12);
            end
        end
        $fclose(fd);

        repeat (10) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;

        foreach (op_q[i]) begin
            case (op_q[i])
                "W": begin
                    apb_access(1'b1, addr_q[i], data_q[i], got_data, got_err);
                    check("pslverr", 32'(got_err), 32'(err_q[i]));
                    if (!got_err)
                        track_write(addr_q[i], data_q[i]);
                end
                "R": begin
                    apb_access(1'b0, addr_q[i], '0, got_data, got_err);
                    check("pslverr", 32'(got_err), 32'(err_q[i]));
                    check("prdata", got_data, rdata_q[i]);
                    if (addr_q[i] == `PS_REG_POS)
                        check("position", got_data,
                              {{(`PS_DATA_W-`PS_STEP_W){shadow_pos[`PS_STEP_W-1]}}, shadow_pos});
                    if (addr_q[i] == `PS_REG_COUNT)
                        check("count", got_data,
                              {{(`PS_DATA_W-`PS_STEP_W){1'b0}}, shadow_count});
                end
                "P": begin
                    do begin
                        apb_access(1'b0, `PS_REG_STATUS, '0, got_data, got_err);
                        check("pslverr", 32'(got_err), 32'd0);
                    end while (got_data[0]);
                    check("psen_count", psen_seen, psen_expected);
                end
                default: begin
                    $display("unknown operation in vector line %0d", i);
                    $display("TEST FAILED");
                    $fatal(1, "bad vector");
                end
            endcase
        end

        check("psen_count", psen_seen, psen_expected);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* design/ps_ctrl_top.sv */
`timescale 1ns/1ps
`include "ps_defines.svh"
`default_nettype none

module ps_ctrl_top (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic [`PS_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`PS_DATA_W-1:0] pwdata,
    output logic [`PS_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  psen,
    output logic                  psincdec,
    input  logic                  psdone
);

    ps_pkg::ps_cmd_t              cmd;
    ps_pkg::ps_status_t           status;
    logic                         cmd_valid;
    logic [`PS_STEP_W-1:0]        gap;
    logic                         clear;
    logic                         busy;
    logic [`PS_STEP_W-1:0]        remaining;
    logic                         step_done;
    logic                         step_dir;
    logic signed [`PS_STEP_W-1:0] position;
    logic [`PS_STEP_W-1:0]        count;

    assign status.busy      = busy;
    assign status.remaining = remaining;
    assign status.position  = position;
    assign status.count     = count;

    ps_apb_decode ps_apb_decode_inst (
        .clk       (clk),
        .aresetn   (aresetn),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .status    (status),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .gap       (gap),
        .clear     (clear)
    );

    ps_step_engine ps_step_engine_inst (
        .clk       (clk),
        .aresetn   (aresetn),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .gap       (gap),
        .psdone    (psdone),
        .psen      (psen),
        .psincdec  (psincdec),
        .busy      (busy),
        .remaining (remaining),
        .step_done (step_done),
        .step_dir  (step_dir)
    );

    ps_position_track ps_position_track_inst (
        .clk       (clk),
        .aresetn   (aresetn),
        .step_done (step_done),
        .step_dir  (step_dir),
        .clear     (clear),
        .position  (position),
        .count     (count)
    );

endmodule

`default_nettype wire

/* design/ps_position_track.sv */
`timescale 1ns/1ps
`include "ps_defines.svh"
`default_nettype none

module ps_position_track (
    input  logic                         clk,
    input  logic                         aresetn,
    input  logic                         step_done,
    input  logic                         step_dir,
    input  logic                         clear,
    output logic signed [`PS_STEP_W-1:0] position,
    output logic        [`PS_STEP_W-1:0] count
);

    logic signed [`PS_STEP_W-1:0] delta;

    // all ones is -1 in two's complement.
    assign delta = step_dir ? `PS_STEP_W'(1) : '1;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            position <= '0;
            count    <= '0;
        end else if (clear) begin
            position <= '0; // wins over a step in the same cycle.
            count    <= '0;
        end else if (step_done) begin
            position <= position + delta;
            count    <= count + `PS_STEP_W'(1);
        end
    end

endmodule

`default_nettype wire

/* design/ps_step_engine.sv */
`timescale 1ns/1ps
`include "ps_defines.svh"
`default_nettype none

module ps_step_engine (
    input  logic                  clk,
    input  logic                  aresetn,
    input  ps_pkg::ps_cmd_t       cmd,
    input  logic                  cmd_valid,
    input  logic [`PS_STEP_W-1:0] gap,
    input  logic                  psdone,
    output logic                  psen,
    output logic                  psincdec,
    output logic                  busy,
    output logic [`PS_STEP_W-1:0] remaining,
    output logic                  step_done,
    output logic                  step_dir
);

    localparam int CNT_W = `PS_STEP_W + 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_GAP,
        ST_PULSE,
        ST_WAIT
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] gap_cnt;
    logic             dir_q;
    logic             last_step;

    assign last_step = remaining == `PS_STEP_W'(1);

    assign psen     = state == ST_PULSE;
    assign busy     = state != ST_IDLE;
    assign psincdec = dir_q; // held for the whole command.
    assign step_dir = dir_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state     <= ST_IDLE;
            gap_cnt   <= '0;
            remaining <= '0;
            dir_q     <= 1'b0;
            step_done <= 1'b0;
        end else begin
            step_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        remaining <= cmd.steps;
                        dir_q     <= cmd.dir;
                        gap_cnt   <= {1'b0, gap};
                        state     <= (gap == '0) ? ST_PULSE : ST_GAP;
                    end
                end
                ST_GAP: begin
                    if (gap_cnt <= CNT_W'(1))
                        state <= ST_PULSE;
                    else
                        gap_cnt <= gap_cnt - CNT_W'(1);
                end
                ST_PULSE: state <= ST_WAIT;
                ST_WAIT: begin
                    if (psdone) begin
                        step_done <= 1'b1;
                        remaining <= remaining - `PS_STEP_W'(1);
                        // one extra cycle covers the step_done slot.
                        gap_cnt   <= {1'b0, gap} + CNT_W'(1);
                        state     <= last_step ? ST_IDLE : ST_GAP;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn) psen |=> !psen);

    assert property (@(posedge clk) disable iff (!aresetn) psdone |-> state == ST_WAIT);

    assert property (@(posedge clk) disable iff (!aresetn) cmd_valid |-> !busy);

endmodule

`default_nettype wire

/* design/ps_apb_decode.sv */
`timescale 1ns/1ps
`include "ps_defines.svh"
`default_nettype none

module ps_apb_decode (
    input  logic                  clk,
    input  logic                  aresetn,
    input  logic [`PS_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`PS_DATA_W-1:0] pwdata,
    output logic [`PS_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  ps_pkg::ps_status_t    status,
    output ps_pkg::ps_cmd_t       cmd,
    output logic                  cmd_valid,
    output logic [`PS_STEP_W-1:0] gap,
    output logic                  clear
);

    localparam int PAD_W = `PS_DATA_W - `PS_STEP_W;

    logic                  access;
    logic                  map_hit;
    logic                  ro_hit;
    logic                  cmd_busy;
    logic                  wr_ok;
    logic [`PS_DATA_W-1:0] rd_data;

    assign access = psel && penable;
    assign pready = access; // no wait states.

    always_comb begin
        map_hit = 1'b1;
        ro_hit  = 1'b0;
        rd_data = '0;
        case (paddr)
            `PS_REG_CMD:    rd_data = '0; // write only.
            `PS_REG_GAP:    rd_data = {{PAD_W{1'b0}}, gap};
            `PS_REG_STATUS: begin
                ro_hit  = 1'b1;
                rd_data = {status.remaining, {(PAD_W - 1){1'b0}}, status.busy};
            end
            `PS_REG_POS: begin
                ro_hit  = 1'b1;
                rd_data = {{PAD_W{status.position[`PS_STEP_W-1]}}, status.position};
            end
            `PS_REG_COUNT: begin
                ro_hit  = 1'b1;
                rd_data = {{PAD_W{1'b0}}, status.count};
            end
            `PS_REG_CLEAR:  rd_data = '0;
            default:        map_hit = 1'b0;
        endcase
    end

    // a new command is refused until the current one finishes.
    assign cmd_busy = (paddr == `PS_REG_CMD) && status.busy;

    assign pslverr = access && (!map_hit || (pwrite && (ro_hit || cmd_busy)));
    assign prdata  = (access && !pwrite && !pslverr) ? rd_data : '0;
    assign wr_ok   = access && pwrite && !pslverr;

    assign cmd.steps = pwdata[`PS_STEP_W-1:0];
    assign cmd.dir   = pwdata[`PS_STEP_W];
    assign cmd_valid = wr_ok && (paddr == `PS_REG_CMD) && (cmd.steps != '0);
    assign clear     = wr_ok && (paddr == `PS_REG_CLEAR) && pwdata[0];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            gap <= `PS_GAP_RESET;
        end else if (wr_ok && (paddr == `PS_REG_GAP)) begin
            gap <= pwdata[`PS_STEP_W-1:0];
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        pready |-> psel && penable);

    // engine must pick up every accepted command.
    assert property (@(posedge clk) disable iff (!aresetn)
        cmd_valid |=> status.busy);

endmodule

`default_nettype wire

/* design/ps_pkg.sv */
`default_nettype none

`include "ps_defines.svh"

package ps_pkg;

    // one phase-shift request as written to CMD.
    typedef struct packed {
        logic                  dir;   // 1 = increment.
        logic [`PS_STEP_W-1:0] steps;
    } ps_cmd_t;

    // live sequencer state as read back over apb.
    typedef struct packed {
        logic                         busy;
        logic        [`PS_STEP_W-1:0] remaining;
        logic signed [`PS_STEP_W-1:0] position;
        logic        [`PS_STEP_W-1:0] count;
    } ps_status_t;

endpackage

`default_nettype wire

/* design/ps_defines.svh */
`ifndef PS_DEFINES_SVH
`define PS_DEFINES_SVH

// apb bus widths.
`define PS_ADDR_W 8
`define PS_DATA_W 32

// step count, phase position and step counter.
`define PS_STEP_W 16

// register map in byte offsets.
`define PS_REG_CMD    8'h00
`define PS_REG_GAP    8'h04
`define PS_REG_STATUS 8'h08
`define PS_REG_POS    8'h0C
`define PS_REG_COUNT  8'h10
`define PS_REG_CLEAR  8'h14

// idle cycles between steps after reset.
`define PS_GAP_RESET 16'd4

`endif
